/* vlog.f */
src/isa_pkg.sv
src/ctrl_pkg.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/control_unit.sv
src/cpu.sv
dv/clk_gen.sv
dv/tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and pass only when the testbench reports a pass
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu -f vlog.f \
	&& ./obj_dir/Vtb_cpu | tee /dev/stderr | grep -F -x '** PASS **' > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

/* dv/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import isa_pkg::*; ();

	localparam int    mem_words   = 256;
	localparam int    reset_limit = 50;
	localparam int    halt_limit  = 2000;
	localparam int    hold_cycles = 20;
	localparam word_t marker      = 16'hde00;
	localparam word_t swd_addr    = 16'h00f2;

	logic  clk;
	logic  reset_n;
	logic  read_m;
	logic  write_m;
	word_t address;
	word_t mem_rdata;
	word_t mem_wdata;
	word_t num_inst;
	word_t output_port;
	logic  is_halted;

	word_t mem [mem_words];
	word_t exp_out [16];       // Distinct output_port values in order
	word_t exp_last  = '0;
	int    exp_len   = 0;
	int    exp_count = 0;      // Instructions on the executed path
	int    load_addr = 0;
	word_t exp_sum;
	word_t exp_next;
	word_t data_a;
	word_t data_b;
	word_t last_port = '0;
	word_t prev_inst = '0;
	logic  reset_d   = 1'b0;
	int    out_idx   = 0;
	int    cycle     = 0;
	int    stores    = 0;
	int    run_errs  = 0;
	int    end_errs  = 0;

	clk_gen i_clk_gen (
		.clk     (clk),
		.reset_n (reset_n)
	);

	cpu i_dut (
		.clk         (clk),
		.reset_n     (reset_n),
		.read_m      (read_m),
		.write_m     (write_m),
		.address     (address),
		.mem_rdata   (mem_rdata),
		.mem_wdata   (mem_wdata),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

	// Memory answers in the same cycle
	assign mem_rdata = mem[address[7:0]];
	assign exp_next  = exp_out[out_idx[3:0]];

	always @(posedge clk) begin
		cycle     <= cycle + 1;
		reset_d   <= reset_n;
		last_port <= output_port;
		prev_inst <= num_inst;
		if (reset_n && write_m) begin
			mem[address[7:0]] <= mem_wdata;
			stores            <= stores + 1;
		end
		if (reset_n && output_port != last_port)
			out_idx <= out_idx + 1;
	end

	task automatic report_error(string msg);
		run_errs++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	task automatic report_final(string msg);
		end_errs++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t encode_r(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
		return {op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic word_t encode_i(logic [3:0] op, reg_idx_t rs, reg_idx_t rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_j(logic [11:0] target);
		return {op_jmp, target};
	endfunction

	task automatic place(word_t code, bit runs);
		mem[load_addr[7:0]] <= code;
		load_addr++;
		if (runs)
			exp_count++;
	endtask

	// A repeated value gives no visible change on the port
	task automatic expect_out(word_t v);
		if (v != exp_last) begin
			exp_out[exp_len[3:0]] = v;
			exp_len++;
			exp_last = v;
		end
	endtask

	task automatic build_program();
		logic [31:0] rng;
		rng    = 32'hb29ef193;
		rng    = xorshift(rng);
		data_a = rng[15:0];
		rng    = xorshift(rng);
		data_b = rng[15:0];
		exp_sum = data_a + data_b;
		for (int i = 0; i < mem_words; i++)
			mem[i[7:0]] <= {8'hee, i[7:0]};
		mem[8'hf0] <= data_a;
		mem[8'hf1] <= data_b;
		place(encode_i(op_lhi, 2'd0, 2'd3, 8'h01), 1);    // r3 = 0x0100 base
		place(encode_r(fn_wwd, 2'd3, 2'd0, 2'd0), 1);
		place(encode_i(op_lwd, 2'd3, 2'd0, 8'hf0), 1);    // Base minus 16 gives 0xF0
		place(encode_i(op_lwd, 2'd3, 2'd1, 8'hf1), 1);
		place(encode_r(fn_add, 2'd0, 2'd1, 2'd2), 1);
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_i(op_swd, 2'd3, 2'd2, 8'hf2), 1);
		place(encode_r(fn_sub, 2'd0, 2'd1, 2'd2), 1);
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_r(fn_and, 2'd0, 2'd1, 2'd2), 1);
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_r(fn_orr, 2'd0, 2'd1, 2'd2), 1);
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_r(fn_not, 2'd0, 2'd0, 2'd2), 1);
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_i(op_adi, 2'd0, 2'd2, 8'h85), 1);    // Negative immediate
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_i(op_lhi, 2'd0, 2'd2, 8'ha5), 1);
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_i(op_lwd, 2'd3, 2'd2, 8'hf2), 1);    // Read back the store
		place(encode_r(fn_wwd, 2'd2, 2'd0, 2'd0), 1);
		place(encode_i(op_lhi, 2'd0, 2'd1, marker[15:8]), 1);
		place(encode_i(op_beq, 2'd0, 2'd0, 8'h01), 1);
		place(encode_r(fn_wwd, 2'd1, 2'd0, 2'd0), 0);     // Skipped marker
		place(encode_i(op_bne, 2'd0, 2'd0, 8'h01), 1);
		place(encode_r(fn_wwd, 2'd0, 2'd0, 2'd0), 1);
		place(encode_j(12'd28), 1);
		place(encode_r(fn_wwd, 2'd1, 2'd0, 2'd0), 0);     // Skipped marker
		place(encode_r(fn_wwd, 2'd3, 2'd0, 2'd0), 1);
		place(encode_r(fn_hlt, 2'd0, 2'd0, 2'd0), 1);
		expect_out(16'h0100);
		expect_out(exp_sum);
		expect_out(data_a - data_b);
		expect_out(data_a & data_b);
		expect_out(data_a | data_b);
		expect_out(~data_a);
		expect_out(data_a + 16'hff85);
		expect_out(16'ha500);
		expect_out(exp_sum);
		expect_out(data_a);
		expect_out(16'h0100);
	endtask

	task automatic wait_for_reset(output bit ok);
		int n;
		n = 0;
		while (!reset_n && n < reset_limit) begin
			@(negedge clk);
			n++;
		end
		ok = reset_n;
		if (!ok)
			$display("Timeout: reset was not released within %0d cycles", reset_limit);
	endtask

	task automatic wait_for_halt(output bit ok);
		int n;
		n = 0;
		while (!is_halted && n < halt_limit) begin
			@(negedge clk);
			n++;
		end
		ok = is_halted;
		if (!ok)
			$display("Timeout: the CPU did not halt within %0d cycles", halt_limit);
	endtask

	a_reset: assert property (@(posedge clk) (cycle > 0 && (!reset_n || !reset_d))
		|-> (num_inst == '0 && !write_m && !is_halted && address == '0 && read_m))
		else report_error($sformatf("reset state expected 0/0/0/0/1 got %h/%h/%b/%b/%b",
			$sampled(num_inst), $sampled(address), $sampled(write_m),
			$sampled(is_halted), $sampled(read_m)));

	a_wwd_value: assert property (@(posedge clk) disable iff (!reset_n)
		(output_port != last_port) |-> (out_idx < exp_len && output_port == exp_next))
		else report_error($sformatf("output_port expected %h got %h (change %0d)",
			$sampled(exp_next), $sampled(output_port), $sampled(out_idx)));

	a_no_marker: assert property (@(posedge clk) disable iff (!reset_n)
		output_port != marker)
		else report_error($sformatf("output_port expected no marker got %h",
			$sampled(output_port)));

	a_store: assert property (@(posedge clk) disable iff (!reset_n)
		write_m |-> (address == swd_addr && mem_wdata == exp_sum))
		else report_error($sformatf("store expected %h at %h got %h at %h",
			exp_sum, swd_addr, $sampled(mem_wdata), $sampled(address)));

	a_count_step: assert property (@(posedge clk) disable iff (!reset_n)
		(num_inst != prev_inst) |-> (num_inst == prev_inst + 16'd1))
		else report_error($sformatf("num_inst expected %h got %h",
			$sampled(prev_inst) + 16'd1, $sampled(num_inst)));

	a_count_gap: assert property (@(posedge clk) disable iff (!reset_n)
		(num_inst != prev_inst) |=> (num_inst == prev_inst))
		else report_error($sformatf("num_inst expected to hold got %h one cycle later",
			$sampled(num_inst)));

	a_halt_stays: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |=> is_halted)
		else report_error("is_halted expected 1 got 0 after halt");

	a_halt_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |-> (!read_m && !write_m))
		else report_error($sformatf("halted memory strobes expected 0/0 got %b/%b",
			$sampled(read_m), $sampled(write_m)));

	a_halt_frozen: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |=> (num_inst == prev_inst && output_port == last_port))
		else report_error($sformatf("halted state expected %h/%h got %h/%h",
			$sampled(prev_inst), $sampled(last_port),
			$sampled(num_inst), $sampled(output_port)));

	initial begin
		bit ok;
		build_program();
		wait_for_reset(ok);
		if (ok)
			wait_for_halt(ok);
		if (ok) begin
			repeat (hold_cycles) @(negedge clk);
			a_final_count: assert (num_inst == word_t'(exp_count))
				else report_final($sformatf("num_inst expected %0d got %0d",
					exp_count, num_inst));
			a_final_outputs: assert (out_idx == exp_len)
				else report_final($sformatf("output changes expected %0d got %0d",
					exp_len, out_idx));
			a_final_stores: assert (stores == 1)
				else report_final($sformatf("stores expected 1 got %0d", stores));
		end
		$display("Errors: %0d during run, %0d in final checks", run_errs, end_errs);
		if (ok && run_errs == 0 && end_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic reset_n
);

	localparam int half_period  = 10;    // 20 ns clock
	localparam int reset_cycles = 4;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		reset_n <= 1'b1;    // Released on a rising edge
	end

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps

module cpu import isa_pkg::*, ctrl_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	output logic  read_m,
	output logic  write_m,
	output word_t address,
	input  word_t mem_rdata,
	output word_t mem_wdata,
	output word_t num_inst,
	output word_t output_port,
	output logic  is_halted
);

	ctrl_t    ctrl;
	inst_t    ir;
	word_t    opnd_a;
	word_t    opnd_b;
	word_t    alu_out;
	word_t    pc;
	word_t    imm;
	word_t    alu_b;
	word_t    alu_y;
	word_t    rd_data1;
	word_t    rd_data2;
	logic     zero;
	reg_idx_t wr_idx;

	assign imm    = sign_ext(ir.low);
	assign alu_b  = ctrl.alu_src_b ? imm : opnd_b;
	assign wr_idx = ctrl.reg_dst ? rd_of(ir) : ir.rt;

	// Fetch uses the PC, data access uses ALU-out
	assign address   = ctrl.ir_write ? pc : alu_out;
	assign read_m    = ctrl.mem_read;
	assign write_m   = ctrl.mem_write;
	assign mem_wdata = opnd_b;    // SWD stores rt

	always_ff @(posedge clk) begin
		if (ctrl.ir_write)
			ir <= mem_rdata;
		if (ctrl.opnd_write) begin
			opnd_a <= rd_data1;
			opnd_b <= rd_data2;
		end
		if (ctrl.alu_out_write)
			alu_out <= ctrl.mem_to_reg ? mem_rdata : alu_y;
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			output_port <= '0;
		else if (ctrl.wwd)
			output_port <= opnd_a;
	end

	control_unit i_control_unit (
		.clk       (clk),
		.reset_n   (reset_n),
		.inst      (ir),
		.ctrl      (ctrl),
		.is_halted (is_halted)
	);

	pc_unit i_pc_unit (
		.clk      (clk),
		.reset_n  (reset_n),
		.ctrl     (ctrl),
		.imm      (imm),
		.target   ({ir.rs, ir.rt, ir.low}),
		.zero     (zero),
		.pc       (pc),
		.num_inst (num_inst)
	);

	reg_file i_reg_file (
		.clk      (clk),
		.reset_n  (reset_n),
		.rd_idx1  (ir.rs),
		.rd_idx2  (ir.rt),
		.wr_idx   (wr_idx),
		.wr_en    (ctrl.reg_write),
		.wr_data  (alu_out),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	alu i_alu (
		.op   (ctrl.alu_op),
		.a    (opnd_a),
		.b    (alu_b),
		.y    (alu_y),
		.zero (zero)
	);

endmodule

/* src/control_unit.sv */
`timescale 1ns/1ps

module control_unit import isa_pkg::*, ctrl_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  inst_t inst,
	output ctrl_t ctrl,
	output logic  is_halted
);

	state_t     state;
	state_t     next_state;
	logic [5:0] funct;

	assign funct     = funct_of(inst);
	assign is_halted = (state == s_halt);

	always_ff @(posedge clk) begin
		if (!reset_n)
			state <= s_if;
		else
			state <= next_state;
	end

	always_comb begin
		ctrl       = '0;
		ctrl.alu_op = alu_add;
		ctrl.pc_src = pc_src_inc;
		next_state = state;
		unique case (state)
			s_if: begin
				ctrl.mem_read = 1'b1;
				ctrl.ir_write = 1'b1;
				ctrl.pc_write = 1'b1;    // PC + 1 at end of fetch
				next_state    = s_id;
			end
			s_id: begin
				ctrl.opnd_write = 1'b1;    // Latch rs and rt
				next_state      = s_ex;
				case (inst.opcode)
					op_jmp: begin
						ctrl.pc_write = 1'b1;
						ctrl.pc_src   = pc_src_jump;
						ctrl.new_inst = 1'b1;
						next_state    = s_if;
					end
					op_rtype: begin
						if (funct == fn_hlt) begin
							ctrl.new_inst = 1'b1;
							next_state    = s_halt;
						end
					end
					op_bne, op_beq, op_adi, op_lhi, op_lwd, op_swd: ;
					default: begin
						// Unknown opcode retires as a no-op
						ctrl.new_inst = 1'b1;
						next_state    = s_if;
					end
				endcase
			end
			s_ex: begin
				ctrl.alu_out_write = 1'b1;
				next_state         = s_wb;
				case (inst.opcode)
					op_rtype: begin
						case (funct)
							fn_add: ctrl.alu_op = alu_add;
							fn_sub: ctrl.alu_op = alu_sub;
							fn_and: ctrl.alu_op = alu_and;
							fn_orr: ctrl.alu_op = alu_orr;
							fn_not: ctrl.alu_op = alu_not;
							fn_wwd: begin
								ctrl.wwd      = 1'b1;
								ctrl.new_inst = 1'b1;
								next_state    = s_if;
							end
							default: begin
								ctrl.new_inst = 1'b1;
								next_state    = s_if;
							end
						endcase
					end
					op_adi: ctrl.alu_src_b = 1'b1;
					op_lhi: begin
						ctrl.alu_op    = alu_lhi;
						ctrl.alu_src_b = 1'b1;
					end
					op_lwd, op_swd: begin
						ctrl.alu_src_b = 1'b1;    // Effective address rs + imm
						next_state     = s_mem;
					end
					op_bne, op_beq: begin
						ctrl.alu_op    = alu_sub;
						ctrl.pc_src    = pc_src_branch;
						ctrl.branch_eq = (inst.opcode == op_beq);
						ctrl.branch_ne = (inst.opcode == op_bne);
						ctrl.new_inst  = 1'b1;
						next_state     = s_if;
					end
					default: begin
						ctrl.new_inst = 1'b1;
						next_state    = s_if;
					end
				endcase
			end
			s_mem: begin
				if (inst.opcode == op_lwd) begin
					ctrl.mem_read      = 1'b1;
					ctrl.alu_out_write = 1'b1;
					ctrl.mem_to_reg    = 1'b1;    // Load word lands in ALU-out
					next_state         = s_wb;
				end else begin
					ctrl.mem_write = 1'b1;
					ctrl.new_inst  = 1'b1;
					next_state     = s_if;
				end
			end
			s_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = (inst.opcode == op_rtype);
				ctrl.new_inst  = 1'b1;
				next_state     = s_if;
			end
			s_halt: ctrl.halt = 1'b1;
			default: next_state = s_if;
		endcase
	end

	a_mem_excl: assert property (@(posedge clk) disable iff (!reset_n)
		!(ctrl.mem_read && ctrl.mem_write))
		else $error("mem_read and mem_write both high");

	a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
		state inside {s_if, s_id, s_ex, s_mem, s_wb, s_halt})
		else $error("illegal state %0d", state);

	a_halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		state == s_halt |=> state == s_halt)
		else $error("left s_halt without reset");

endmodule

/* src/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import isa_pkg::*, ctrl_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  ctrl_t       ctrl,
	input  word_t       imm,
	input  logic [11:0] target,
	input  logic        zero,
	output word_t       pc,
	output word_t       num_inst
);

	word_t pc_next;
	logic  taken;

	assign taken = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

	always_comb begin
		case (ctrl.pc_src)
			pc_src_branch: pc_next = pc + imm;    // PC already points past the branch
			pc_src_jump:   pc_next = {pc[word_w-1:12], target};
			default:       pc_next = pc + word_t'(1);
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			pc <= '0;
		else if (ctrl.pc_write || taken)
			pc <= pc_next;
	end

	// Retired instruction count
	always_ff @(posedge clk) begin
		if (!reset_n)
			num_inst <= '0;
		else if (ctrl.new_inst)
			num_inst <= num_inst + word_t'(1);
	end

	a_count_frozen: assert property (@(posedge clk) disable iff (!reset_n)
		ctrl.halt |=> $stable(num_inst))
		else $error("num_inst moved while halted");

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  reg_idx_t rd_idx1,
	input  reg_idx_t rd_idx2,
	input  reg_idx_t wr_idx,
	input  logic     wr_en,
	input  word_t    wr_data,
	output word_t    rd_data1,
	output word_t    rd_data2
);

	word_t regs [num_regs];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			foreach (regs[i])
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Reads see the old value during a write cycle
	assign rd_data1 = regs[rd_idx1];
	assign rd_data2 = regs[rd_idx2];

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu import isa_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   y,
	output logic    zero
);

	always_comb begin
		unique case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_orr: y = a | b;
			alu_not: y = ~a;              // Unary on rs
			alu_lhi: y = {b[7:0], 8'h00};
			default: y = a + b;
		endcase
	end

	// Equality flag for BEQ and BNE whatever the op
	assign zero = (a == b);

endmodule

/* src/ctrl_pkg.sv */
package ctrl_pkg;

	import isa_pkg::*;

	typedef enum logic [2:0] {
		s_if,
		s_id,
		s_ex,
		s_mem,
		s_wb,
		s_halt
	} state_t;

	// Next PC selection
	localparam logic [1:0] pc_src_inc    = 2'd0;
	localparam logic [1:0] pc_src_branch = 2'd1;
	localparam logic [1:0] pc_src_jump   = 2'd2;

	typedef struct packed {
		logic       mem_read;
		logic       mem_write;
		logic       ir_write;
		logic       pc_write;
		logic [1:0] pc_src;
		logic       branch_eq;
		logic       branch_ne;
		logic       opnd_write;
		alu_op_t    alu_op;
		logic       alu_src_b;       // 1 selects sign-extended imm
		logic       alu_out_write;
		logic       reg_write;
		logic       reg_dst;         // 1 selects rd, else rt
		logic       mem_to_reg;
		logic       wwd;
		logic       new_inst;
		logic       halt;
	} ctrl_t;

endpackage

/* src/isa_pkg.sv */
package isa_pkg;

	localparam int word_w   = 16;
	localparam int num_regs = 4;

	typedef logic [word_w-1:0] word_t;
	typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

	// Shared layout of R, I and J formats
	typedef struct packed {
		logic [3:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		logic [7:0] low;    // rd and funct, or imm8
	} inst_t;

	localparam logic [3:0] op_bne   = 4'd0;
	localparam logic [3:0] op_beq   = 4'd1;
	localparam logic [3:0] op_adi   = 4'd4;
	localparam logic [3:0] op_lhi   = 4'd6;
	localparam logic [3:0] op_lwd   = 4'd7;
	localparam logic [3:0] op_swd   = 4'd8;
	localparam logic [3:0] op_jmp   = 4'd9;
	localparam logic [3:0] op_rtype = 4'd15;

	localparam logic [5:0] fn_add = 6'd0;
	localparam logic [5:0] fn_sub = 6'd1;
	localparam logic [5:0] fn_and = 6'd2;
	localparam logic [5:0] fn_orr = 6'd3;
	localparam logic [5:0] fn_not = 6'd4;
	localparam logic [5:0] fn_wwd = 6'd28;
	localparam logic [5:0] fn_hlt = 6'd29;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_orr,
		alu_not,
		alu_lhi    // Immediate into the high byte
	} alu_op_t;

	function automatic logic [5:0] funct_of(inst_t inst);
		return inst.low[5:0];
	endfunction

	function automatic reg_idx_t rd_of(inst_t inst);
		return inst.low[7:6];
	endfunction

	function automatic word_t sign_ext(logic [7:0] imm);
		return {{(word_w-8){imm[7]}}, imm};
	endfunction

endpackage
